//--- files.f
sync_pkg.sv
sync_node.sv
sync_root.sv
sync_cfg_regs.sv
sync_top.sv
tb_sync_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the barrier network testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_sync_top \
  --Mdir "$BUILD_DIR" -o sim_tb \
  -f files.f

"./$BUILD_DIR/sim_tb" | tee "$LOG"

# Verdict comes from the log
if grep -q "Simulation completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- sync_cfg_regs.sv
// ==========================================================
// Barrier network APB register block
// Enable, root wake delay and saturating event counters
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sync_cfg_regs (
  input  logic                clk,
  input  logic                arst_n_i,
  // APB slave, zero wait states
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  sync_pkg::apb_addr_t paddr_i,
  input  sync_pkg::apb_data_t pwdata_i,
  output sync_pkg::apb_data_t prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // To the tree
  output logic                en_o,
  output sync_pkg::delay_t    delay_o,
  // Event pulses from the tree
  input  logic [1:0]          pair_evt_i,  // One per leaf
  input  logic                all_evt_i,
  input  logic                sys_evt_i,
  input  logic [2:0]          err_evt_i    // Leaf 0, leaf 1, top node
);

  import sync_pkg::*;

  logic   en_q;
  delay_t delay_q;
  cnt_t   cnt_pair_q;
  cnt_t   cnt_all_q;
  cnt_t   cnt_sys_q;
  cnt_t   cnt_err_q;

  logic      access;    // APB access phase
  logic      addr_hit;  // Mapped register
  logic      addr_cnt;  // Counter register, read only
  logic      wr_ok;
  logic      clr;
  apb_data_t rdata;
  logic [1:0] pair_inc;
  logic [1:0] err_inc;

  // Add 0..3 and stick at the top value
  function automatic cnt_t sat_add(input cnt_t val, input logic [1:0] inc);
    logic [$bits(cnt_t):0] sum;
    sum = {1'b0, val} + ($bits(cnt_t) + 1)'(inc);
    if (sum[$bits(cnt_t)]) begin
      return '1;
    end
    return sum[$bits(cnt_t)-1:0];
  endfunction

  assign access = psel_i && penable_i;

  // Address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    addr_cnt = 1'b0;
    rdata    = '0;
    case (paddr_i)
      REG_CTRL:  rdata = apb_data_t'(en_q);  // Clear bit reads 0
      REG_DELAY: rdata = apb_data_t'(delay_q);
      REG_CNT_PAIR: begin
        rdata    = apb_data_t'(cnt_pair_q);
        addr_cnt = 1'b1;
      end
      REG_CNT_ALL: begin
        rdata    = apb_data_t'(cnt_all_q);
        addr_cnt = 1'b1;
      end
      REG_CNT_SYS: begin
        rdata    = apb_data_t'(cnt_sys_q);
        addr_cnt = 1'b1;
      end
      REG_CNT_ERR: begin
        rdata    = apb_data_t'(cnt_err_q);
        addr_cnt = 1'b1;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  assign wr_ok = access && pwrite_i && addr_hit && !addr_cnt;
  assign clr   = wr_ok && (paddr_i == REG_CTRL) && pwdata_i[CTRL_CLR_BIT];

  // Both leaves may finish in the same cycle
  assign pair_inc = 2'(pair_evt_i[0]) + 2'(pair_evt_i[1]);
  assign err_inc  = 2'(err_evt_i[0]) + 2'(err_evt_i[1]) + 2'(err_evt_i[2]);

  // Control and delay registers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q    <= 1'b0;
      delay_q <= '0;
    end else if (wr_ok) begin
      if (paddr_i == REG_CTRL) begin
        en_q <= pwdata_i[CTRL_EN_BIT];
      end
      if (paddr_i == REG_DELAY) begin
        delay_q <= pwdata_i[$bits(delay_t)-1:0];
      end
    end
  end

  // Event counters, clear wins over a same-cycle event
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_pair_q <= '0;
      cnt_all_q  <= '0;
      cnt_sys_q  <= '0;
      cnt_err_q  <= '0;
    end else if (clr) begin
      cnt_pair_q <= '0;
      cnt_all_q  <= '0;
      cnt_sys_q  <= '0;
      cnt_err_q  <= '0;
    end else begin
      cnt_pair_q <= sat_add(cnt_pair_q, pair_inc);
      cnt_all_q  <= sat_add(cnt_all_q, {1'b0, all_evt_i});
      cnt_sys_q  <= sat_add(cnt_sys_q, {1'b0, sys_evt_i});
      cnt_err_q  <= sat_add(cnt_err_q, err_inc);
    end
  end

  assign prdata_o  = (psel_i && !pwrite_i) ? rdata : '0;
  assign pready_o  = 1'b1;
  assign pslverr_o = access && (!addr_hit || (pwrite_i && addr_cnt));  // Unmapped or RO write
  assign en_o      = en_q;
  assign delay_o   = delay_q;

  // Every access phase comes right after a setup phase
  assert property (@(posedge clk) disable iff (!arst_n_i)
    penable_i |-> (psel_i && $past(psel_i && !penable_i)));

endmodule

`default_nettype wire

//--- sync_node.sv
// ==========================================================
// Barrier combining node with two children
// Resolves barriers of its own level, flags level mismatches
// and forwards higher levels to the parent
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sync_node #(
  parameter sync_pkg::lvl_t NODE_LVL = sync_pkg::LVL_PAIR
) (
  input  logic           clk,
  input  logic           arst_n_i,
  input  logic           en_i,        // Accept new requests
  // Child side
  input  logic           c0_req_i,
  input  sync_pkg::lvl_t c0_lvl_i,
  input  logic           c1_req_i,
  input  sync_pkg::lvl_t c1_lvl_i,
  output logic           c0_wake_o,
  output logic           c1_wake_o,
  output logic           c_error_o,   // Valid with wake only
  // Parent side
  output logic           up_req_o,
  output sync_pkg::lvl_t up_lvl_o,
  input  logic           up_wake_i,
  input  logic           up_error_i,
  // Event pulses for the counters
  output logic           done_o,
  output logic           err_o
);

  import sync_pkg::*;

  node_state_t state_q;

  logic wake_q;
  logic error_q;
  logic up_req_q;
  logic done_q;
  logic err_q;
  lvl_t up_lvl_q;

  logic both_req;
  logic accept;
  logic lvl_bad;  // Mismatch, zero or below this node
  logic lvl_fwd;  // Belongs to a node further up

  assign both_req = c0_req_i && c1_req_i;
  assign accept   = (state_q == IDLE) && both_req && en_i;

  // A leaf resolves its own level, so anything below NODE_LVL is a protocol error
  assign lvl_bad = (c0_lvl_i != c1_lvl_i) || (c0_lvl_i == LVL_NONE) ||
                   (c0_lvl_i < NODE_LVL);
  assign lvl_fwd = !lvl_bad && (c0_lvl_i > NODE_LVL);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      wake_q   <= 1'b0;
      error_q  <= 1'b0;
      up_req_q <= 1'b0;
      done_q   <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      // Pulses by default
      wake_q  <= 1'b0;
      error_q <= 1'b0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            if (lvl_bad) begin
              state_q <= WAKE;
              wake_q  <= 1'b1;
              error_q <= 1'b1;
              err_q   <= 1'b1;
            end else if (lvl_fwd) begin
              state_q  <= WAIT_PARENT;
              up_req_q <= 1'b1;  // Rises with the same edge
            end else begin
              state_q <= WAKE;  // Local barrier done
              wake_q  <= 1'b1;
              done_q  <= 1'b1;
            end
          end
        end
        WAIT_PARENT: begin
          if (up_wake_i) begin
            state_q  <= WAKE;
            up_req_q <= 1'b0;        // Drop after seeing wake
            wake_q   <= 1'b1;
            error_q  <= up_error_i;  // Pass parent verdict down
          end
        end
        // Children still hold their requests here, so no accept
        WAKE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Forwarded level is only meaningful while up_req_o is high
  always_ff @(posedge clk) begin
    if (accept && lvl_fwd) begin
      up_lvl_q <= c0_lvl_i;
    end
  end

  assign c0_wake_o = wake_q;
  assign c1_wake_o = wake_q;
  assign c_error_o = error_q;
  assign up_req_o  = up_req_q;
  assign up_lvl_o  = up_lvl_q;
  assign done_o    = done_q;
  assign err_o     = err_q;

  // Wake only goes to children that are still waiting
  assert property (@(posedge clk) disable iff (!arst_n_i)
    wake_q |-> (c0_req_i && c1_req_i));

  // Child requests held until woken
  assert property (@(posedge clk) disable iff (!arst_n_i)
    (c0_req_i && !wake_q) |=> c0_req_i);

  assert property (@(posedge clk) disable iff (!arst_n_i)
    (c1_req_i && !wake_q) |=> c1_req_i);

endmodule

`default_nettype wire

//--- sync_pkg.sv
// ==========================================================
// Barrier network shared definitions
// Widths, level codes, APB register map and node FSM type
// ==========================================================

`default_nettype none

package sync_pkg;

  // Fixed 2x2 mesh
  localparam int unsigned N_TILES = 4;

  // Barrier level carried with every request
  typedef logic [1:0] lvl_t;

  localparam lvl_t LVL_NONE = 2'd0;  // Invalid, always an error
  localparam lvl_t LVL_PAIR = 2'd1;  // Tile and its pair partner
  localparam lvl_t LVL_ALL  = 2'd2;  // All four tiles
  localparam lvl_t LVL_SYS  = 2'd3;  // Goes up to the root responder

  // Root wake delay in cycles
  typedef logic [7:0] delay_t;

  // Event counter, saturates at all ones
  typedef logic [15:0] cnt_t;

  // APB
  typedef logic [4:0]  apb_addr_t;  // Byte address
  typedef logic [31:0] apb_data_t;

  // Register map
  // CTRL bit 0 enables the tree, bit 1 clears all counters (W1, self-clearing)
  localparam apb_addr_t REG_CTRL     = 5'h00;
  localparam apb_addr_t REG_DELAY    = 5'h04;  // Root wake delay
  localparam apb_addr_t REG_CNT_PAIR = 5'h08;  // Completed pair barriers
  localparam apb_addr_t REG_CNT_ALL  = 5'h0C;  // Completed all-tile barriers
  localparam apb_addr_t REG_CNT_SYS  = 5'h10;  // Completed system barriers
  localparam apb_addr_t REG_CNT_ERR  = 5'h14;  // Level mismatches

  // CTRL bit positions
  localparam int unsigned CTRL_EN_BIT  = 0;
  localparam int unsigned CTRL_CLR_BIT = 1;

  // Combining node FSM
  typedef enum logic [1:0] {
    IDLE,         // Waiting for both children
    WAIT_PARENT,  // Request forwarded, parent not answered yet
    WAKE          // Wake pulse to the children
  } node_state_t;

endpackage

`default_nettype wire

//--- sync_root.sv
// ==========================================================
// Barrier root responder
// Answers system barriers after the programmed wake delay
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sync_root (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             en_i,
  input  sync_pkg::delay_t delay_i,   // Cycles between accept and wake
  input  logic             req_i,
  input  sync_pkg::lvl_t   lvl_i,
  output logic             wake_o,
  output logic             error_o,   // Valid with wake only
  output logic             done_o     // System barrier completed
);

  import sync_pkg::*;

  logic   busy_q;   // Counting down
  delay_t cnt_q;
  logic   bad_q;    // Level seen at accept was not LVL_SYS
  logic   wake_q;
  logic   error_q;
  logic   done_q;

  logic accept;
  logic bad_now;
  logic fire;
  logic fire_bad;

  // Requester still holds req during the wake cycle
  assign accept  = req_i && en_i && !busy_q && !wake_q;
  assign bad_now = (lvl_i != LVL_SYS);

  // Zero delay wakes right after the accept edge
  assign fire     = (accept && (delay_i == '0)) || (busy_q && (cnt_q == delay_t'(1)));
  assign fire_bad = accept ? bad_now : bad_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      wake_q  <= 1'b0;
      error_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      wake_q  <= fire;
      error_q <= fire && fire_bad;
      done_q  <= fire && !fire_bad;
      if (accept && (delay_i != '0)) begin
        busy_q <= 1'b1;
        cnt_q  <= delay_i;
      end else if (busy_q) begin
        cnt_q <= cnt_q - delay_t'(1);
        if (cnt_q == delay_t'(1)) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Level check result kept until the wake
  always_ff @(posedge clk) begin
    if (accept) begin
      bad_q <= bad_now;
    end
  end

  assign wake_o  = wake_q;
  assign error_o = error_q;
  assign done_o  = done_q;

  // One wake per request
  assert property (@(posedge clk) disable iff (!arst_n_i)
    wake_o |=> !wake_o);

endmodule

`default_nettype wire

//--- sync_top.sv
// ==========================================================
// Barrier network top level for the 2x2 mesh
// Two pair leaves, one all-tile node, root and APB registers
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module sync_top (
  input  logic                                    clk,
  input  logic                                    arst_n_i,
  // APB slave
  input  logic                                    psel_i,
  input  logic                                    penable_i,
  input  logic                                    pwrite_i,
  input  sync_pkg::apb_addr_t                     paddr_i,
  input  sync_pkg::apb_data_t                     pwdata_i,
  output sync_pkg::apb_data_t                     prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  // Tiles
  input  logic [sync_pkg::N_TILES-1:0]            tile_req_i,
  input  sync_pkg::lvl_t [sync_pkg::N_TILES-1:0]  tile_lvl_i,
  output logic [sync_pkg::N_TILES-1:0]            tile_wake_o,
  output logic [sync_pkg::N_TILES-1:0]            tile_error_o
);

  import sync_pkg::*;

  logic   en;
  delay_t delay;

  // Leaf to top node
  logic leaf0_up_req, leaf1_up_req;
  lvl_t leaf0_up_lvl, leaf1_up_lvl;
  logic leaf0_up_wake, leaf1_up_wake;
  logic top_c_error;  // Shared by both leaves
  logic leaf0_c_error, leaf1_c_error;

  // Top node to root
  logic top_up_req;
  lvl_t top_up_lvl;
  logic root_wake, root_error, root_done;

  // Events
  logic leaf0_done, leaf1_done, top_done;
  logic leaf0_err, leaf1_err, top_err;

  // Pair error goes to both tiles of the pair
  assign tile_error_o = {{2{leaf1_c_error}}, {2{leaf0_c_error}}};

  sync_node #(.NODE_LVL(LVL_PAIR)) i_leaf0 (
    .clk(clk), .arst_n_i(arst_n_i), .en_i(en),
    .c0_req_i(tile_req_i[0]), .c0_lvl_i(tile_lvl_i[0]),
    .c1_req_i(tile_req_i[1]), .c1_lvl_i(tile_lvl_i[1]),
    .c0_wake_o(tile_wake_o[0]), .c1_wake_o(tile_wake_o[1]), .c_error_o(leaf0_c_error),
    .up_req_o(leaf0_up_req), .up_lvl_o(leaf0_up_lvl),
    .up_wake_i(leaf0_up_wake), .up_error_i(top_c_error),
    .done_o(leaf0_done), .err_o(leaf0_err)
  );

  sync_node #(.NODE_LVL(LVL_PAIR)) i_leaf1 (
    .clk(clk), .arst_n_i(arst_n_i), .en_i(en),
    .c0_req_i(tile_req_i[2]), .c0_lvl_i(tile_lvl_i[2]),
    .c1_req_i(tile_req_i[3]), .c1_lvl_i(tile_lvl_i[3]),
    .c0_wake_o(tile_wake_o[2]), .c1_wake_o(tile_wake_o[3]), .c_error_o(leaf1_c_error),
    .up_req_o(leaf1_up_req), .up_lvl_o(leaf1_up_lvl),
    .up_wake_i(leaf1_up_wake), .up_error_i(top_c_error),
    .done_o(leaf1_done), .err_o(leaf1_err)
  );

  // All-tile level, system barriers go on to the root
  sync_node #(.NODE_LVL(LVL_ALL)) i_node_top (
    .clk(clk), .arst_n_i(arst_n_i), .en_i(en),
    .c0_req_i(leaf0_up_req), .c0_lvl_i(leaf0_up_lvl),
    .c1_req_i(leaf1_up_req), .c1_lvl_i(leaf1_up_lvl),
    .c0_wake_o(leaf0_up_wake), .c1_wake_o(leaf1_up_wake), .c_error_o(top_c_error),
    .up_req_o(top_up_req), .up_lvl_o(top_up_lvl),
    .up_wake_i(root_wake), .up_error_i(root_error),
    .done_o(top_done), .err_o(top_err)
  );

  sync_root i_root (
    .clk(clk), .arst_n_i(arst_n_i), .en_i(en), .delay_i(delay),
    .req_i(top_up_req), .lvl_i(top_up_lvl),
    .wake_o(root_wake), .error_o(root_error), .done_o(root_done)
  );

  sync_cfg_regs i_cfg (
    .clk(clk), .arst_n_i(arst_n_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .en_o(en), .delay_o(delay),
    .pair_evt_i({leaf1_done, leaf0_done}),
    .all_evt_i(top_done),
    .sys_evt_i(root_done),
    .err_evt_i({top_err, leaf1_err, leaf0_err})
  );

endmodule

`default_nettype wire

//--- tb_sync_top.sv
// ============================================================
// Barrier network testbench
// Plays the four tiles and the APB master, checks wake timing,
// error flags and the event counters
// ============================================================

`timescale 1ns/1ps
`default_nettype none

module tb_sync_top;

  import sync_pkg::*;

  localparam int RST_CYCLES   = 5;
  localparam int APB_TIMEOUT  = 16;   // Zero wait states expected
  localparam int WAKE_TIMEOUT = 400;  // Covers the largest root delay used
  localparam int IDLE_CYCLES  = 50;
  localparam int unsigned SEED = 32'h7fa2;

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  apb_addr_t                paddr;
  apb_data_t                pwdata;
  apb_data_t                prdata;
  logic                     pready;
  logic                     pslverr;
  logic [N_TILES-1:0]       tile_req;
  lvl_t [N_TILES-1:0]       tile_lvl;
  logic [N_TILES-1:0]       tile_wake;
  logic [N_TILES-1:0]       tile_error;

  int cyc = 0;       // Edges seen before the current one
  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int exp_pair = 0;  // Reference counter values
  int exp_all = 0;
  int exp_sys = 0;
  int exp_err = 0;

  // Per tile results of the last barrier
  int   req_seen [N_TILES];  // First cycle the DUT sees the request
  int   wake_at  [N_TILES];
  logic err_at   [N_TILES];

  sync_top i_sync_top (
    .clk(clk), .arst_n_i(arst_n),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .tile_req_i(tile_req), .tile_lvl_i(tile_lvl),
    .tile_wake_o(tile_wake), .tile_error_o(tile_error)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_data(input string what, input apb_data_t got, input apb_data_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("FAIL %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic slverr);
    int   n;
    logic ready;
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    n     = 0;
    ready = 1'b0;
    while (!ready && n < APB_TIMEOUT) begin
      @(posedge clk);
      n++;
      ready = pready;
    end
    rdata   = prdata;
    slverr  = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    if (!ready) begin
      $display("Timeout: APB access to 0x%0h never saw pready", addr);
      timeouts++;
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic slverr);
    apb_data_t unused;
    apb_access(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic slverr);
    apb_access(1'b0, addr, '0, data, slverr);
  endtask

  task automatic write_ok(input apb_addr_t addr, input apb_data_t data);
    logic slverr;
    apb_write(addr, data, slverr);
    check_flag($sformatf("pslverr on write to 0x%0h", addr), slverr, 1'b0);
  endtask

  task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string what);
    apb_data_t data;
    logic      slverr;
    apb_read(addr, data, slverr);
    check_data(what, data, exp);
    check_flag({what, " pslverr"}, slverr, 1'b0);
  endtask

  // Tile model, request held until wake then dropped
  task automatic tile_barrier(input int t, input lvl_t lvl, input int offset);
    int n;
    repeat (offset) @(posedge clk);
    tile_req[t] <= 1'b1;
    tile_lvl[t] <= lvl;
    req_seen[t] = cyc + 1;
    wake_at[t]  = -1;
    err_at[t]   = 1'b0;
    n = 0;
    while (wake_at[t] < 0 && n < WAKE_TIMEOUT) begin
      @(posedge clk);
      n++;
      if (tile_wake[t]) begin
        wake_at[t] = cyc;
        err_at[t]  = tile_error[t];
      end
    end
    tile_req[t] <= 1'b0;
    tile_lvl[t] <= LVL_NONE;
    if (wake_at[t] < 0) begin
      $display("Timeout: tile %0d got no wake within %0d cycles", t, WAKE_TIMEOUT);
      timeouts++;
    end
  endtask

  // Expected error per tile and counter increments from the node rule
  function automatic void expect_barrier(input lvl_t [N_TILES-1:0] lv,
                                         input logic [N_TILES-1:0] act,
                                         output logic [N_TILES-1:0] err,
                                         output int inc_pair, output int inc_all,
                                         output int inc_sys, output int inc_err);
    logic [1:0] fwd;
    lvl_t       flvl [2];
    int         p;
    err      = '0;
    inc_pair = 0;
    inc_all  = 0;
    inc_sys  = 0;
    inc_err  = 0;
    for (p = 0; p < 2; p++) begin
      fwd[p]  = 1'b0;
      flvl[p] = LVL_NONE;
      if (act[2*p] && act[2*p+1]) begin
        if (lv[2*p] != lv[2*p+1] || lv[2*p] == LVL_NONE) begin
          err[2*p +: 2] = 2'b11;  // Leaf mismatch
          inc_err++;
        end else if (lv[2*p] == LVL_PAIR) begin
          inc_pair++;
        end else begin
          fwd[p]  = 1'b1;
          flvl[p] = lv[2*p];
        end
      end
    end
    if (fwd == 2'b11) begin
      if (flvl[0] != flvl[1]) begin
        err = '1;  // Top node mismatch reaches every tile
        inc_err++;
      end else if (flvl[0] == LVL_ALL) begin
        inc_all++;
      end else begin
        inc_sys++;
      end
    end
  endfunction

  task automatic tally(input lvl_t [N_TILES-1:0] lv, input logic [N_TILES-1:0] act);
    logic [N_TILES-1:0] err;
    int ip;
    int ia;
    int is;
    int ie;
    int t;
    expect_barrier(lv, act, err, ip, ia, is, ie);
    exp_pair += ip;
    exp_all  += ia;
    exp_sys  += is;
    exp_err  += ie;
    for (t = 0; t < N_TILES; t++) begin
      if (act[t]) check_flag($sformatf("tile %0d error", t), err_at[t], err[t]);
    end
  endtask

  // Random start offsets, latency taken from the latest request of the group
  task automatic run_barrier(input lvl_t [N_TILES-1:0] lv, input logic [N_TILES-1:0] act,
                             input int max_off, input logic group_all,
                             input int lat_min, input int lat_max);
    int off [N_TILES];
    int ref_cyc;
    int lat;
    int t;
    int u;
    for (t = 0; t < N_TILES; t++) off[t] = $urandom_range(max_off, 0);
    fork
      if (act[0]) tile_barrier(0, lv[0], off[0]);
      if (act[1]) tile_barrier(1, lv[1], off[1]);
      if (act[2]) tile_barrier(2, lv[2], off[2]);
      if (act[3]) tile_barrier(3, lv[3], off[3]);
    join
    tally(lv, act);
    for (t = 0; t < N_TILES; t++) begin
      if (act[t]) begin
        ref_cyc = 0;
        for (u = 0; u < N_TILES; u++) begin
          if (act[u] && (group_all || u / 2 == t / 2) && req_seen[u] > ref_cyc)
            ref_cyc = req_seen[u];
        end
        lat = wake_at[t] - ref_cyc;
        if (lat_min == lat_max) check_latency($sformatf("tile %0d wake latency", t), lat, lat_min);
        else check_flag($sformatf("tile %0d latency in window", t),
                        lat >= lat_min && lat <= lat_max, 1'b1);
      end
    end
    @(posedge clk);  // Requests drop before the next barrier
  endtask

  // Two levels that some leaf must reject
  function automatic logic [3:0] mismatched_pair();
    lvl_t a;
    lvl_t b;
    a = lvl_t'($urandom_range(3, 0));
    b = lvl_t'($urandom_range(3, 0));
    if (a == b && a != LVL_NONE) b = a ^ 2'b01;
    return {b, a};
  endfunction

  initial begin
    lvl_t [N_TILES-1:0] lv;
    apb_data_t          data;
    logic               slverr;
    int                 d;
    int                 i;
    void'($urandom(SEED));
    arst_n   <= 1'b0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    paddr    <= '0;
    pwdata   <= '0;
    tile_req <= '0;
    tile_lvl <= '0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // Register access and reset values
    read_expect(REG_CTRL, '0, "CTRL after reset");
    read_expect(REG_DELAY, '0, "DELAY after reset");
    read_expect(REG_CNT_PAIR, '0, "CNT_PAIR after reset");
    read_expect(REG_CNT_ALL, '0, "CNT_ALL after reset");
    read_expect(REG_CNT_SYS, '0, "CNT_SYS after reset");
    read_expect(REG_CNT_ERR, '0, "CNT_ERR after reset");
    write_ok(REG_CTRL, 32'h1);
    read_expect(REG_CTRL, 32'h1, "CTRL readback");
    write_ok(REG_CTRL, 32'h0);
    read_expect(REG_CTRL, 32'h0, "CTRL readback");
    write_ok(REG_DELAY, 32'h1A5);
    read_expect(REG_DELAY, 32'hA5, "DELAY readback");  // 8 bits kept
    apb_read(5'h18, data, slverr);
    check_flag("pslverr on unmapped read", slverr, 1'b1);
    apb_write(REG_CNT_ALL, 32'h55, slverr);
    check_flag("pslverr on counter write", slverr, 1'b1);
    read_expect(REG_CNT_ALL, '0, "CNT_ALL after rejected write");

    // Pair request parked while disabled
    fork
      tile_barrier(0, LVL_PAIR, 0);
      tile_barrier(1, LVL_PAIR, 0);
      begin
        repeat (IDLE_CYCLES) begin
          @(posedge clk);
          check_flag("wake while disabled", |tile_wake, 1'b0);
        end
        write_ok(REG_CTRL, 32'h1);
      end
    join
    tally({LVL_NONE, LVL_NONE, LVL_PAIR, LVL_PAIR}, 4'b0011);
    @(posedge clk);

    // Pair barriers on both leaves
    for (i = 0; i < 8; i++) run_barrier({4{LVL_PAIR}}, 4'b1111, 6, 1'b0, 1, 1);
    read_expect(REG_CNT_PAIR, apb_data_t'(exp_pair), "CNT_PAIR");

    // All-tile barriers
    for (i = 0; i < 4; i++) run_barrier({4{LVL_ALL}}, 4'b1111, 6, 1'b1, 3, 3);
    read_expect(REG_CNT_ALL, apb_data_t'(exp_all), "CNT_ALL");

    // System barriers through the root
    for (i = 0; i < 4; i++) begin
      d = $urandom_range(20, 0);
      write_ok(REG_DELAY, apb_data_t'(d));
      run_barrier({4{LVL_SYS}}, 4'b1111, 6, 1'b1, d, d + 5);
    end
    read_expect(REG_CNT_SYS, apb_data_t'(exp_sys), "CNT_SYS");

    // Level mismatches at the leaves, then at the top node
    for (i = 0; i < 6; i++) begin
      lv = {mismatched_pair(), mismatched_pair()};
      run_barrier(lv, 4'b1111, 4, 1'b0, 1, 1);
    end
    run_barrier({LVL_SYS, LVL_SYS, LVL_ALL, LVL_ALL}, 4'b1111, 4, 1'b1, 3, 3);
    read_expect(REG_CNT_ERR, apb_data_t'(exp_err), "CNT_ERR");
    write_ok(REG_CTRL, 32'h3);  // Keep enable, clear counters
    read_expect(REG_CTRL, 32'h1, "CTRL after clear");
    read_expect(REG_CNT_PAIR, '0, "CNT_PAIR after clear");
    read_expect(REG_CNT_ALL, '0, "CNT_ALL after clear");
    read_expect(REG_CNT_SYS, '0, "CNT_SYS after clear");
    read_expect(REG_CNT_ERR, '0, "CNT_ERR after clear");

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
